// File: mem_req_pkg.sv
// shared address map, line geometry and bus types for the memory request controller
package mem_req_pkg;

	// --------------------
	// geometry
	// --------------------

	// 8 regions of 2 banks each
	localparam int NUM_BANKS = 16;
	// one sram line
	localparam int LINE_BYTES = 32;

	// --------------------
	// scalar types
	// --------------------

	// byte address, 512 KB space
	typedef logic [18:0] addr_t;
	// {region, odd/even}
	typedef logic [3:0] bank_t;
	// line within a bank
	typedef logic [9:0] line_idx_t;
	// 1..32 bytes, zero never issued
	typedef logic [5:0] size_t;
	// byte position inside a line
	typedef logic [4:0] offset_t;
	typedef logic [LINE_BYTES-1:0][7:0] line_t;
	typedef logic [LINE_BYTES-1:0] byte_en_t;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} op_e;

	// per-client request sequencing
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		DONE
	} req_state_e;

	// --------------------
	// bundles
	// --------------------

	// client side, held stable until valid or ack
	typedef struct packed {
		logic req;
		op_e op;
		addr_t addr;
		size_t size;
		line_t wdata;
	} client_req_t;

	// back to the client, valid for reads and ack for writes
	typedef struct packed {
		logic valid;
		logic ack;
		line_t rdata;
	} client_rsp_t;

	// one command per bank in the grant cycle
	typedef struct packed {
		logic read;
		logic write;
		line_idx_t line_idx;
		line_t wdata;
		byte_en_t byte_en;
	} bank_cmd_t;

	// decoded request, first line and optional second line
	typedef struct packed {
		bank_t first_bank;
		bank_t second_bank;
		logic two_lines;
		bank_cmd_t first_cmd;
		bank_cmd_t second_cmd;
		offset_t offset;
	} line_plan_t;

	// --------------------
	// address map helpers
	// --------------------

	// region in 18..16, bank parity in bit 5
	function automatic bank_t bank_of(addr_t addr);
		return {addr[18:16], addr[5]};
	endfunction

	// bits 15..6 index the line, bit 5 already spent on the bank
	function automatic line_idx_t line_of(addr_t addr);
		return addr[15:6];
	endfunction

endpackage

// File: line_splitter.sv
// combinational decode of one client request into first and second line commands
`timescale 1ns/1ns
module line_splitter (
	input mem_req_pkg::client_req_t req,
	output mem_req_pkg::line_plan_t plan
);
	import mem_req_pkg::*;

	// byte offset of the start address
	offset_t offset;
	// next line start that may carry into the next region
	addr_t next_addr;
	// 1..32 bytes left in the first line
	size_t room;
	size_t first_cnt;
	size_t second_cnt;
	logic two_lines;
	logic is_read;
	logic is_write;
	// flat view of the write data for shifting
	logic [LINE_BYTES*8-1:0] wvec;
	logic [LINE_BYTES*8-1:0] first_wvec;
	logic [LINE_BYTES*8-1:0] second_wvec;
	byte_en_t first_be;
	byte_en_t second_be;

	// low cnt bytes enabled up to a full line
	function automatic byte_en_t lead_mask(size_t cnt);
		logic [LINE_BYTES:0] m;
		m = ({{LINE_BYTES{1'b0}}, 1'b1} << cnt) - 1'b1;
		return m[LINE_BYTES-1:0];
	endfunction

	// --------------------
	// geometry
	// --------------------

	always_comb begin
		offset = req.addr[4:0];
		next_addr = req.addr + addr_t'(LINE_BYTES);
		room = size_t'(LINE_BYTES) - size_t'(offset);
		// first line takes what fits and second takes the rest
		first_cnt = (req.size > room) ? room : req.size;
		second_cnt = req.size - first_cnt;
		// crossing the line end needs a second bank
		two_lines = (7'(offset) + 7'(req.size)) > 7'(LINE_BYTES);
	end

	// --------------------
	// write alignment
	// --------------------

	always_comb begin
		wvec = req.wdata;
		// lead bytes land at the offset
		first_wvec = wvec << {offset, 3'b000};
		// remaining bytes start at byte 0 of the next line
		second_wvec = wvec >> {first_cnt, 3'b000};
		first_be = lead_mask(first_cnt) << offset;
		// empty when everything fits in the first line
		second_be = lead_mask(second_cnt);
	end

	// idle client gives idle commands
	assign is_read = req.req && (req.op == OP_READ);
	assign is_write = req.req && (req.op == OP_WRITE);

	// --------------------
	// plan assembly
	// --------------------

	always_comb begin
		plan.first_bank = bank_of(req.addr);
		plan.second_bank = bank_of(next_addr);
		plan.two_lines = two_lines;
		plan.offset = offset;

		plan.first_cmd.read = is_read;
		plan.first_cmd.write = is_write;
		plan.first_cmd.line_idx = line_of(req.addr);
		plan.first_cmd.wdata = first_wvec;
		plan.first_cmd.byte_en = first_be;

		// only meaningful when two_lines is set
		plan.second_cmd.read = is_read && two_lines;
		plan.second_cmd.write = is_write && two_lines;
		plan.second_cmd.line_idx = line_of(next_addr);
		plan.second_cmd.wdata = second_wvec;
		plan.second_cmd.byte_en = second_be;
	end

endmodule

// File: client_req_fsm.sv
// per-client sequencer: bank requests, grant tracking, read capture and completion pulses
`timescale 1ns/1ns
module client_req_fsm (
	input logic clk,
	input logic rst_n,
	input mem_req_pkg::client_req_t req,
	input mem_req_pkg::line_plan_t plan,
	input logic [mem_req_pkg::NUM_BANKS-1:0] gnt_col,
	input mem_req_pkg::line_t [mem_req_pkg::NUM_BANKS-1:0] bank_rdata,
	output logic [mem_req_pkg::NUM_BANKS-1:0] bank_req_col,
	output mem_req_pkg::client_rsp_t rsp
);
	import mem_req_pkg::*;

	req_state_e state;
	req_state_e next_state;
	// op of the running request, the client may change req during DONE
	op_e op_q;
	// lines still waiting for a grant
	logic pend_first;
	logic pend_second;
	// one-cycle flags, sram data arrives the cycle after the grant
	logic cap_first;
	logic cap_second;
	logic gnt_first;
	logic gnt_second;
	logic all_clear;
	line_t line_first;
	line_t line_second;
	line_t rdata_q;
	// second line above first, for realignment
	logic [2*LINE_BYTES*8-1:0] joined;

	// --------------------
	// grant decode
	// --------------------

	// the two banks always differ, bit 5 flips between lines
	assign gnt_first = gnt_col[plan.first_bank];
	assign gnt_second = gnt_col[plan.second_bank];

	// nothing granted-but-missing and nothing still in flight
	assign all_clear = !pend_first && !pend_second && !cap_first && !cap_second;

	// raise a request for every line not yet granted
	always_comb begin
		bank_req_col = '0;
		if (state == ISSUE) begin
			if (pend_first)
				bank_req_col[plan.first_bank] = 1'b1;
			if (pend_second)
				bank_req_col[plan.second_bank] = 1'b1;
		end
	end

	// --------------------
	// state machine
	// --------------------

	always_comb begin
		next_state = state;
		case (state)
			IDLE:
				if (req.req)
					next_state = ISSUE;
			ISSUE:
				if (all_clear)
					next_state = DONE;
			// done lasts one cycle
			DONE:
				next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			op_q <= OP_READ;
			pend_first <= 1'b0;
			pend_second <= 1'b0;
			cap_first <= 1'b0;
			cap_second <= 1'b0;
		end else begin
			state <= next_state;
			cap_first <= 1'b0;
			cap_second <= 1'b0;
			if (state == IDLE && req.req) begin
				// arm one or both lines
				op_q <= req.op;
				pend_first <= 1'b1;
				pend_second <= plan.two_lines;
			end else if (state == ISSUE) begin
				// a grant retires its line
				if (pend_first && gnt_first) begin
					pend_first <= 1'b0;
					cap_first <= (op_q == OP_READ);
				end
				if (pend_second && gnt_second) begin
					pend_second <= 1'b0;
					cap_second <= (op_q == OP_READ);
				end
			end
		end
	end

	// --------------------
	// read capture and realignment
	// --------------------

	always_ff @(posedge clk) begin
		if (cap_first)
			line_first <= bank_rdata[plan.first_bank];
		if (cap_second)
			line_second <= bank_rdata[plan.second_bank];
	end

	// drop the leading offset bytes of the first line
	assign joined = {line_second, line_first} >> {plan.offset, 3'b000};

	// result frozen on the way into DONE
	always_ff @(posedge clk) begin
		if (state == ISSUE && all_clear)
			rdata_q <= joined[LINE_BYTES*8-1:0];
	end

	always_comb begin
		rsp.valid = (state == DONE) && (op_q == OP_READ);
		rsp.ack = (state == DONE) && (op_q == OP_WRITE);
		rsp.rdata = rdata_q;
	end

	// --------------------
	// checks
	// --------------------

	// arbiter grants only banks this client asked for
	a_gnt_requested: assert property (@(posedge clk) disable iff (!rst_n)
		(gnt_col & ~bank_req_col) == '0)
		else $error("grant on a bank without a request");

	// a raised request is not withdrawn before its grant
	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		($past(bank_req_col & ~gnt_col) & ~bank_req_col) == '0)
		else $error("bank request dropped without a grant");

endmodule

// File: bank_cmd_mux.sv
// per-bank selection of the granted client's line command toward the srams
`timescale 1ns/1ns
module bank_cmd_mux #(
	parameter int NUM_CLIENTS = 4
) (
	input mem_req_pkg::line_plan_t [NUM_CLIENTS-1:0] plans,
	input logic [mem_req_pkg::NUM_BANKS-1:0][NUM_CLIENTS-1:0] gnt,
	output mem_req_pkg::bank_cmd_t [mem_req_pkg::NUM_BANKS-1:0] bank_cmd
);
	import mem_req_pkg::*;

	// --------------------
	// command select
	// --------------------

	// zero cycles from gnt to bank_cmd
	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			// idle when nobody holds the bank
			bank_cmd[b] = '0;
			for (int c = 0; c < NUM_CLIENTS; c++) begin
				if (gnt[b][c]) begin
					// first line if this is the client's first bank
					if (plans[c].first_bank == bank_t'(b))
						bank_cmd[b] = plans[c].first_cmd;
					// otherwise it can only be the crossing line
					else
						bank_cmd[b] = plans[c].second_cmd;
				end
			end
		end
	end

	// --------------------
	// arbiter check
	// --------------------

	// at most one owner per bank, else commands would collide
	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			a_gnt_onehot: assert ($onehot0(gnt[b]))
				else $error("bank %0d granted to more than one client", b);
		end
	end

endmodule

// File: mem_req_ctrl.sv
// top of the banked sram request controller, one decoder and sequencer per client
`timescale 1ns/1ns
module mem_req_ctrl #(
	parameter int NUM_CLIENTS = 4
) (
	input logic clk,
	input logic rst_n,
	input mem_req_pkg::client_req_t [NUM_CLIENTS-1:0] client_req,
	output mem_req_pkg::client_rsp_t [NUM_CLIENTS-1:0] client_rsp,
	output logic [mem_req_pkg::NUM_BANKS-1:0][NUM_CLIENTS-1:0] bank_req,
	input logic [mem_req_pkg::NUM_BANKS-1:0][NUM_CLIENTS-1:0] gnt,
	output mem_req_pkg::bank_cmd_t [mem_req_pkg::NUM_BANKS-1:0] bank_cmd,
	input mem_req_pkg::line_t [mem_req_pkg::NUM_BANKS-1:0] bank_rdata
);
	import mem_req_pkg::*;

	// decoded requests, shared with the bank mux
	line_plan_t [NUM_CLIENTS-1:0] plans;

	// --------------------
	// per-client path
	// --------------------

	for (genvar c = 0; c < NUM_CLIENTS; c++) begin : g_client
		// this client's column of the bank x client matrices
		logic [NUM_BANKS-1:0] gnt_col;
		logic [NUM_BANKS-1:0] req_col;

		for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
			assign gnt_col[b] = gnt[b][c];
			assign bank_req[b][c] = req_col[b];
		end

		line_splitter u_split (
			.req (client_req[c]),
			.plan (plans[c])
		);

		client_req_fsm u_fsm (
			.clk (clk),
			.rst_n (rst_n),
			.req (client_req[c]),
			.plan (plans[c]),
			.gnt_col (gnt_col),
			.bank_rdata (bank_rdata),
			.bank_req_col (req_col),
			.rsp (client_rsp[c])
		);
	end

	// --------------------
	// bank side
	// --------------------

	bank_cmd_mux #(
		.NUM_CLIENTS (NUM_CLIENTS)
	) u_mux (
		.plans (plans),
		.gnt (gnt),
		.bank_cmd (bank_cmd)
	);

endmodule

// File: tb_mem_req_ctrl.sv
// testbench for mem_req_ctrl: random clients, arbiter and sram models, byte reference memory
`timescale 1ns/1ns
module tb_mem_req_ctrl;
	import mem_req_pkg::*;

	localparam int NC = 4;
	// negedges allowed per access
	localparam int TIMEOUT = 400;
	localparam int TRAFFIC_OPS = 40;

	logic clk = 1'b0;
	logic rst_n;
	client_req_t [NC-1:0] client_req;
	client_rsp_t [NC-1:0] client_rsp;
	logic [NUM_BANKS-1:0][NC-1:0] bank_req;
	logic [NUM_BANKS-1:0][NC-1:0] gnt = '0;
	bank_cmd_t [NUM_BANKS-1:0] bank_cmd;
	line_t [NUM_BANKS-1:0] bank_rdata = '0;
	integer seed;
	// sram contents, bank then line index
	line_t sram [NUM_BANKS][1024];
	// flat image of the whole address space
	logic [7:0] ref_mem [0:(1<<19)-1];

	mem_req_ctrl #(
		.NUM_CLIENTS (NC)
	) UUT (
		.clk (clk),
		.rst_n (rst_n),
		.client_req (client_req),
		.client_rsp (client_rsp),
		.bank_req (bank_req),
		.gnt (gnt),
		.bank_cmd (bank_cmd),
		.bank_rdata (bank_rdata)
	);

	always #50 clk = ~clk;

	// --------------------
	// arbiter and sram
	// --------------------

	always @(negedge clk) begin : arb_sram
		int start;
		int idx;
		// commands of the grant cycle that just ended
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (bank_cmd[b].read)
				bank_rdata[b] = sram[b][bank_cmd[b].line_idx];
			if (bank_cmd[b].write)
				for (int k = 0; k < LINE_BYTES; k++)
					if (bank_cmd[b].byte_en[k])
						sram[b][bank_cmd[b].line_idx][k] = bank_cmd[b].wdata[k];
		end
		// about half the requested banks get one random owner
		for (int b = 0; b < NUM_BANKS; b++) begin
			gnt[b] = '0;
			start = {$random(seed)} % NC;
			if (bank_req[b] != '0 && ($random(seed) & 1))
				for (int k = 0; k < NC; k++) begin
					idx = (start + k) % NC;
					if (bank_req[b][idx] && gnt[b] == '0)
						gnt[b][idx] = 1'b1;
				end
		end
	end

	// --------------------
	// checks
	// --------------------

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_failure($sformatf("FAIL %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_col(input string name, input logic [NUM_BANKS-1:0] exp,
			input logic [NUM_BANKS-1:0] act);
		if (act !== exp)
			report_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
	endtask

	// only the first size bytes carry data
	task automatic check_line(input string name, input line_t exp, input line_t act,
			input size_t size);
		for (int k = 0; k < int'(size); k++)
			if (act[k] !== exp[k])
				report_failure($sformatf("FAIL %s byte %0d expected %h actual %h",
					name, k, exp, act));
	endtask

	// every address bit feeds the pattern
	function automatic logic [7:0] fill_byte(addr_t a);
		return a[7:0] ^ a[15:8] ^ {a[18:16], 5'h0b};
	endfunction

	function automatic line_t rand_line();
		logic [LINE_BYTES*8-1:0] v;
		for (int i = 0; i < LINE_BYTES / 4; i++)
			v[i*32 +: 32] = $random(seed);
		return v;
	endfunction

	// one request through the handshake, starting and ending on a negedge
	task automatic run_access(input int c, input op_e op, input addr_t addr, input size_t size,
			input line_t wdata, input string name);
		logic [NUM_BANKS-1:0] col;
		logic [NUM_BANKS-1:0] exp_col;
		addr_t nxt;
		line_t exp;
		int waited;
		client_req[c].op = op;
		client_req[c].addr = addr;
		client_req[c].size = size;
		client_req[c].wdata = wdata;
		client_req[c].req = 1'b1;
		@(negedge clk);
		// first ISSUE cycle, every line requested together
		for (int b = 0; b < NUM_BANKS; b++)
			col[b] = bank_req[b][c];
		exp_col = '0;
		exp_col[{addr[18:16], addr[5]}] = 1'b1;
		nxt = addr + addr_t'(LINE_BYTES);
		if (int'(addr[4:0]) + int'(size) > LINE_BYTES)
			exp_col[{nxt[18:16], nxt[5]}] = 1'b1;
		check_col({name, " bank_req"}, exp_col, col);
		waited = 0;
		while (!(client_rsp[c].valid || client_rsp[c].ack)) begin
			if (waited == TIMEOUT)
				report_failure({name, ": no valid or ack came back before the timeout"});
			waited++;
			@(negedge clk);
		end
		check_bit({name, " valid"}, op == OP_READ, client_rsp[c].valid);
		check_bit({name, " ack"}, op == OP_WRITE, client_rsp[c].ack);
		if (op == OP_READ) begin
			for (int k = 0; k < LINE_BYTES; k++)
				exp[k] = ref_mem[addr + addr_t'(k)];
			check_line(name, exp, client_rsp[c].rdata, size);
		end else begin
			for (int k = 0; k < int'(size); k++)
				ref_mem[addr + addr_t'(k)] = wdata[k];
		end
		client_req[c].req = 1'b0;
		@(negedge clk);
		// pulse is one cycle wide
		check_bit({name, " single pulse"}, 1'b0, client_rsp[c].valid | client_rsp[c].ack);
	endtask

	// own block in line bits 15..14, banks still shared with the others
	task automatic client_traffic(input int c);
		addr_t addr;
		op_e op;
		size_t size;
		for (int i = 0; i < TRAFFIC_OPS; i++) begin
			op = ($random(seed) & 1) ? OP_WRITE : OP_READ;
			size = size_t'(1 + {$random(seed)} % 32);
			addr = {3'($random(seed)), 2'(c), 14'({$random(seed)} % (16384 - 32))};
			run_access(c, op, addr, size, rand_line(), $sformatf("traffic c%0d #%0d", c, i));
		end
	endtask

	// --------------------
	// test sequence
	// --------------------

	initial begin
		addr_t addr;
		size_t size;
		int off;
		seed = 32'hff25_de6e;
		rst_n = 1'b0;
		client_req = '0;
		for (int a = 0; a < (1 << 19); a++) begin
			ref_mem[a] = fill_byte(addr_t'(a));
			sram[{a[18:16], a[5]}][a[15:6]][a[4:0]] = fill_byte(addr_t'(a));
		end
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		// quiet outputs with no requests
		repeat (4) begin
			@(negedge clk);
			check_bit("idle bank_req", 1'b0, |bank_req);
			for (int i = 0; i < NC; i++) begin
				check_bit("idle valid", 1'b0, client_rsp[i].valid);
				check_bit("idle ack", 1'b0, client_rsp[i].ack);
			end
		end

		// full aligned lines
		for (int i = 0; i < 20; i++) begin
			addr = addr_t'({$random(seed)}) & ~addr_t'(31);
			run_access({$random(seed)} % NC, OP_WRITE, addr, 6'd32, rand_line(), "aligned write");
			run_access({$random(seed)} % NC, OP_READ, addr, 6'd32, '0, "aligned read");
		end

		// crossings, region wrap first
		run_access(0, OP_WRITE, {3'd3, 11'h7ff, 5'd20}, 6'd24, rand_line(), "region wrap write");
		run_access(1, OP_READ, {3'd3, 11'h7ff, 5'd20}, 6'd24, '0, "region wrap read");
		for (int i = 0; i < 20; i++) begin
			off = 1 + {$random(seed)} % 31;
			size = size_t'(33 - off + {$random(seed)} % off);
			addr = addr_t'({$random(seed)});
			addr[4:0] = 5'(off);
			run_access({$random(seed)} % NC, OP_WRITE, addr, size, rand_line(), "cross write");
			run_access({$random(seed)} % NC, OP_READ, addr, size, '0, "cross read");
		end

		// partial writes, neighbours read back
		for (int i = 0; i < 20; i++) begin
			addr = addr_t'({$random(seed)});
			size = size_t'(1 + {$random(seed)} % 16);
			run_access({$random(seed)} % NC, OP_WRITE, addr, size, rand_line(), "partial write");
			run_access({$random(seed)} % NC, OP_READ, addr - addr_t'(8), 6'd32, '0,
				"partial readback");
		end

		// all clients under random grants
		fork
			client_traffic(0);
			client_traffic(1);
			client_traffic(2);
			client_traffic(3);
		join

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: vlog.f
mem_req_pkg.sv
line_splitter.sv
client_req_fsm.sv
bank_cmd_mux.sv
mem_req_ctrl.sv
tb_mem_req_ctrl.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f vlog.f \
		--top-module tb_mem_req_ctrl -o sim_tb

run: build
	./obj_dir/sim_tb | tee sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only --timing -f vlog.f --top-module mem_req_ctrl

clean:
	rm -rf obj_dir sim.log
